// ==== src.f ====
+incdir+include
hw/pwm_reg_pkg.sv
hw/shadow_reg.sv
hw/wb_reg_port.sv
hw/global_regs.sv
hw/channel_regs.sv
hw/read_mux.sv
hw/pwm_reg_if.sv
sim/tb_pwm_reg_if.sv

// ==== Bender.yml ====
package:
  name: pwm_reg_if

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/pwm_reg_pkg.sv
      - hw/shadow_reg.sv
      - hw/wb_reg_port.sv
      - hw/global_regs.sv
      - hw/channel_regs.sv
      - hw/read_mux.sv
      - hw/pwm_reg_if.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_pwm_reg_if.sv

// ==== sim/tb_pwm_reg_if.sv ====
/* self-checking testbench for pwm_reg_if, outputs compared against a register model every cycle
   bus transactions and load events never overlap, so a write and a load never share a cycle */
`timescale 1ns/1ns
`include "pwm_reg_defs.svh"

module tb_pwm_reg_if;

  import pwm_reg_pkg::*;

  localparam int unsigned SEED = 32'h911184d8;
  // about 600 transactions of 3 cycles plus loads and reset
  localparam int TIMEOUT_CYCLES = 5000;
  localparam chan_en_t MASK = `PWM_SHADOW_MASK;

  logic        pclk;
  logic        rst_n;
  wb_req_t     wb_req;
  logic        wb_ack;
  word_t       wb_dat_r;
  word_t       period_cnt;
  logic        sync_pulse;
  global_cfg_t global_cfg;
  edge_cfg_t   edge_cfg;

  // register model
  word_t     pre_prescale;
  word_t     act_prescale;
  word_t     pre_period;
  word_t     act_period;
  chan_en_t  pre_enable;
  chan_en_t  act_enable;
  edge_cfg_t pre_edges;
  edge_cfg_t act_edges;
  logic      sync_upd;

  int   cycle_count;
  logic prev_req;
  logic prev_ack;

  pwm_reg_if DUT (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .period_cnt (period_cnt),
    .sync_pulse (sync_pulse),
    .global_cfg (global_cfg),
    .edge_cfg   (edge_cfg)
  );

  initial
  begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;
  end

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      $display("Error: %s expected %h got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_global(input global_cfg_t exp, input global_cfg_t act);
    if (act !== exp)
    begin
      $display("Error: global_cfg expected %h got %h", exp, act);
      stop_run();
    end
  endtask

  task automatic check_edges(input edge_cfg_t exp, input edge_cfg_t act);
    if (act !== exp)
    begin
      $display("Error: edge_cfg expected %h got %h", exp, act);
      stop_run();
    end
  endtask

  // masked channels show the active copy, the others what software wrote
  function automatic global_cfg_t ref_global();
    global_cfg_t g;
    g.prescale = act_prescale;
    g.period   = act_period;
    for (int k = 0; k < `PWM_CHANNELS; k++)
      g.enable[k] = MASK[k] ? act_enable[k] : pre_enable[k];
    return g;
  endfunction

  function automatic edge_cfg_t ref_edges();
    edge_cfg_t e;
    for (int k = 0; k < `PWM_CHANNELS; k++)
      e[k] = MASK[k] ? act_edges[k] : pre_edges[k];
    return e;
  endfunction

  function automatic word_t ref_read(input reg_addr_t addr);
    global_cfg_t g;
    edge_cfg_t   e;
    int          off;
    word_t       rd;
    g   = ref_global();
    e   = ref_edges();
    off = int'(addr) - `PWM_ADDR_EDGE_BASE;
    rd  = '0;
    if (addr == reg_addr_t'(`PWM_ADDR_PRESCALE))
      rd = g.prescale;
    else if (addr == reg_addr_t'(`PWM_ADDR_PERIOD))
      rd = g.period;
    else if (addr == reg_addr_t'(`PWM_ADDR_ENABLE))
      rd = word_t'(g.enable);
    else if (addr == reg_addr_t'(`PWM_ADDR_SYNC_UPDATE))
      rd = word_t'(sync_upd);
    else if (off >= 0 && off < 2 * `PWM_CHANNELS)
      rd = (off % 2 == 0) ? e[off / 2].rise : e[off / 2].fall;
    return rd;
  endfunction

  task automatic reset_model();
    pre_prescale = `PWM_RST_PRESCALE;
    act_prescale = `PWM_RST_PRESCALE;
    pre_period   = `PWM_RST_PERIOD;
    act_period   = `PWM_RST_PERIOD;
    pre_enable   = '0;
    act_enable   = '0;
    pre_edges    = '0;
    act_edges    = '0;
    sync_upd     = 1'b0;
  endtask

  task automatic model_write(input reg_addr_t addr, input word_t data);
    int off;
    off = int'(addr) - `PWM_ADDR_EDGE_BASE;
    if (addr == reg_addr_t'(`PWM_ADDR_PRESCALE))
      pre_prescale = data;
    else if (addr == reg_addr_t'(`PWM_ADDR_PERIOD))
      pre_period = data;
    else if (addr == reg_addr_t'(`PWM_ADDR_ENABLE))
      pre_enable = chan_en_t'(data);
    else if (addr == reg_addr_t'(`PWM_ADDR_SYNC_UPDATE))
      sync_upd = data[0];
    else if (off >= 0 && off < 2 * `PWM_CHANNELS)
    begin
      if (off % 2 == 0)
        pre_edges[off / 2].rise = data;
      else
        pre_edges[off / 2].fall = data;
    end
  endtask

  task automatic model_load(input word_t cnt);
    if (cnt >= act_period)
    begin
      act_prescale = pre_prescale;
      act_period   = pre_period;
      act_enable   = pre_enable;
      if (sync_upd)
        act_edges = pre_edges;
    end
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do
    begin
      @(negedge pclk);
      n++;
    end while (!wb_ack && n < 4);
    if (!wb_ack)
    begin
      $display("no ack arrived for a pending request");
      stop_run();
    end
    else if (n != 2)
    begin
      $display("ack did not follow the request by exactly one cycle");
      stop_run();
    end
  endtask

  task automatic wb_write(input reg_addr_t addr, input word_t data);
    @(posedge pclk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
    wait_ack();
    // the write commits at the edge that ends the ack cycle
    @(posedge pclk);
    wb_req <= '0;
    model_write(addr, data);
  endtask

  task automatic wb_read(input reg_addr_t addr);
    @(posedge pclk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: '0};
    wait_ack();
    check_word($sformatf("wb_dat_r[%0d]", addr), ref_read(addr), wb_dat_r);
    @(posedge pclk);
    wb_req <= '0;
  endtask

  task automatic read_all();
    for (int a = 0; a < 64; a++)
      wb_read(reg_addr_t'(a));
  endtask

  task automatic pulse_sync(input word_t cnt);
    @(posedge pclk);
    sync_pulse <= 1'b1;
    period_cnt <= cnt;
    @(posedge pclk);
    sync_pulse <= 1'b0;
    model_load(cnt);
  endtask

  // handshake monitor and output comparison
  always @(negedge pclk)
  begin
    if (rst_n)
    begin
      if (wb_ack && !(prev_req && !prev_ack))
      begin
        $display("ack raised without a fresh request or held longer than one cycle");
        stop_run();
      end
      check_global(ref_global(), global_cfg);
      check_edges(ref_edges(), edge_cfg);
    end
    prev_req = wb_req.cyc && wb_req.stb;
    prev_ack = wb_ack;
  end

  always @(posedge pclk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("the test timed out after %0d cycles", cycle_count);
      stop_run();
    end
  end

  initial
  begin
    int    op;
    word_t data;
    void'($urandom(SEED));
    cycle_count = 0;
    prev_req    = 1'b0;
    prev_ack    = 1'b0;
    reset_model();
    wb_req     <= '0;
    period_cnt <= '0;
    sync_pulse <= 1'b0;
    rst_n      <= 1'b0;
    repeat (16) @(posedge pclk);
    rst_n <= 1'b1;
    @(negedge pclk);
    check_word("wb_dat_r", '0, wb_dat_r);
    read_all();

    // unmasked channels show at once, the rest waits for a load
    wb_write(reg_addr_t'(`PWM_ADDR_ENABLE), 8'hFF);
    wb_write(reg_addr_t'(`PWM_ADDR_EDGE_BASE + 2), 8'h21);
    wb_write(reg_addr_t'(`PWM_ADDR_EDGE_BASE + 3), 8'h61);
    wb_write(reg_addr_t'(`PWM_ADDR_EDGE_BASE + 12), 8'h36);
    wb_write(reg_addr_t'(`PWM_ADDR_EDGE_BASE + 13), 8'h76);
    wb_write(reg_addr_t'(`PWM_ADDR_PRESCALE), 8'h03);
    wb_write(reg_addr_t'(`PWM_ADDR_PERIOD), 8'd20);
    read_all();

    // below the period nothing loads, then globals load but edges stay
    pulse_sync(8'd5);
    pulse_sync(8'd8);
    read_all();
    wb_write(reg_addr_t'(`PWM_ADDR_SYNC_UPDATE), 8'h01);
    pulse_sync(8'd19);
    pulse_sync(8'd20);
    read_all();

    for (int i = 0; i < 500; i++)
    begin
      op   = $urandom_range(0, 9);
      data = word_t'($urandom);
      if (op < 4)
        wb_write(reg_addr_t'($urandom), data);
      else if (op < 8)
        wb_read(reg_addr_t'($urandom));
      else
        pulse_sync(data);
    end
    read_all();

    $display("Test OK");
    $finish;
  end

endmodule

// ==== hw/pwm_reg_if.sv ====
/* PWM register interface top, wishbone classic slave for 8 channels of 8-bit data
   period_cnt and sync_pulse come from an external timebase in the pclk domain */
`timescale 1ns/1ns

module pwm_reg_if (
  input  logic                     pclk,
  input  logic                     rst_n,
  input  pwm_reg_pkg::wb_req_t     wb_req,
  output logic                     wb_ack,
  output pwm_reg_pkg::word_t       wb_dat_r,
  input  pwm_reg_pkg::word_t       period_cnt,
  input  logic                     sync_pulse,
  output pwm_reg_pkg::global_cfg_t global_cfg,
  output pwm_reg_pkg::edge_cfg_t   edge_cfg
);

  import pwm_reg_pkg::*;

  reg_addr_t rd_addr;
  word_t     rd_data;
  reg_wr_t   reg_wr;
  logic      channel_load;
  logic      sync_update;

  wb_reg_port u_wb_reg_port (
    .pclk     (pclk),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .reg_wr   (reg_wr)
  );

  global_regs u_global_regs (
    .pclk         (pclk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .period_cnt   (period_cnt),
    .sync_pulse   (sync_pulse),
    .global_cfg   (global_cfg),
    .channel_load (channel_load),
    .sync_update  (sync_update)
  );

  channel_regs u_channel_regs (
    .pclk         (pclk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .channel_load (channel_load),
    .edge_cfg     (edge_cfg)
  );

  read_mux u_read_mux (
    .rd_addr     (rd_addr),
    .global_cfg  (global_cfg),
    .edge_cfg    (edge_cfg),
    .sync_update (sync_update),
    .rd_data     (rd_data)
  );

endmodule

// ==== hw/read_mux.sv ====
/* combinational readback decode over the 64-word map
   returns the same values the generator sees, unmapped words read zero */
`timescale 1ns/1ns
`include "pwm_reg_defs.svh"

module read_mux (
  input  pwm_reg_pkg::reg_addr_t   rd_addr,
  input  pwm_reg_pkg::global_cfg_t global_cfg,
  input  pwm_reg_pkg::edge_cfg_t   edge_cfg,
  input  logic                     sync_update,
  output pwm_reg_pkg::word_t       rd_data
);

  import pwm_reg_pkg::*;

  always_comb
  begin
    case (rd_addr)
      reg_addr_t'(`PWM_ADDR_PRESCALE):
        rd_data = global_cfg.prescale;
      reg_addr_t'(`PWM_ADDR_PERIOD):
        rd_data = global_cfg.period;
      reg_addr_t'(`PWM_ADDR_ENABLE):
        rd_data = word_t'(global_cfg.enable);
      reg_addr_t'(`PWM_ADDR_SYNC_UPDATE):
        rd_data = {{(`PWM_DW - 1){1'b0}}, sync_update};
      default:
        rd_data = '0;
    endcase

    // edge words, two per channel
    for (int k = 0; k < `PWM_CHANNELS; k++)
    begin
      if (rd_addr == reg_addr_t'(`PWM_ADDR_EDGE_BASE + 2 * k))
      begin
        rd_data = edge_cfg[k].rise;
      end
      if (rd_addr == reg_addr_t'(`PWM_ADDR_EDGE_BASE + 2 * k + 1))
      begin
        rd_data = edge_cfg[k].fall;
      end
    end
  end

endmodule

// ==== hw/channel_regs.sv ====
/* rise and fall compare registers of every channel
   active copies load only on channel_load, which already carries the sync_update qualifier */
`timescale 1ns/1ns
`include "pwm_reg_defs.svh"

module channel_regs (
  input  logic                   pclk,
  input  logic                   rst_n,
  input  pwm_reg_pkg::reg_wr_t   reg_wr,
  input  logic                   channel_load,
  output pwm_reg_pkg::edge_cfg_t edge_cfg
);

  import pwm_reg_pkg::*;

  localparam chan_en_t SHADOW_MASK = `PWM_SHADOW_MASK;

  genvar k;

  generate
    for (k = 0; k < `PWM_CHANNELS; k++)
    begin : g_chan
      localparam reg_addr_t RISE_ADDR = reg_addr_t'(`PWM_ADDR_EDGE_BASE + 2 * k);
      localparam reg_addr_t FALL_ADDR = reg_addr_t'(`PWM_ADDR_EDGE_BASE + 2 * k + 1);

      logic       wr_rise;
      logic       wr_fall;
      edge_pair_t wr_pair;
      edge_pair_t pre_pair;
      edge_pair_t act_pair;

      assign wr_rise = reg_wr.valid && (reg_wr.addr == RISE_ADDR);
      assign wr_fall = reg_wr.valid && (reg_wr.addr == FALL_ADDR);

      // only the addressed half of the pair changes
      assign wr_pair = '{
        rise: wr_rise ? reg_wr.data : pre_pair.rise,
        fall: wr_fall ? reg_wr.data : pre_pair.fall
      };

      shadow_reg #(
        .T       (edge_pair_t),
        .RST_VAL ('0)
      ) u_edge (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .wr_en      (wr_rise || wr_fall),
        .wr_data    (wr_pair),
        .load       (channel_load),
        .pre_val    (pre_pair),
        .active_val (act_pair)
      );

      assign edge_cfg[k] = SHADOW_MASK[k] ? act_pair : pre_pair;
    end
  endgenerate

endmodule

// ==== hw/global_regs.sv ====
/* prescale, period, enable and sync_update registers with load-event detection
   prescale and period are always seen through the active copy */
`timescale 1ns/1ns
`include "pwm_reg_defs.svh"

module global_regs (
  input  logic                     pclk,
  input  logic                     rst_n,
  input  pwm_reg_pkg::reg_wr_t     reg_wr,
  input  pwm_reg_pkg::word_t       period_cnt,
  input  logic                     sync_pulse,
  output pwm_reg_pkg::global_cfg_t global_cfg,
  output logic                     channel_load,
  output logic                     sync_update
);

  import pwm_reg_pkg::*;

  localparam chan_en_t SHADOW_MASK = `PWM_SHADOW_MASK;

  logic     wr_prescale;
  logic     wr_period;
  logic     wr_enable;
  logic     load_event;
  word_t    act_prescale;
  word_t    act_period;
  chan_en_t pre_enable;
  chan_en_t act_enable;
  chan_en_t vis_enable;

  assign wr_prescale = reg_wr.valid && (reg_wr.addr == reg_addr_t'(`PWM_ADDR_PRESCALE));
  assign wr_period   = reg_wr.valid && (reg_wr.addr == reg_addr_t'(`PWM_ADDR_PERIOD));
  assign wr_enable   = reg_wr.valid && (reg_wr.addr == reg_addr_t'(`PWM_ADDR_ENABLE));

  // end of a period as seen by the timebase
  assign load_event   = sync_pulse && (period_cnt >= act_period);
  assign channel_load = load_event && sync_update;

  shadow_reg #(
    .T       (word_t),
    .RST_VAL (word_t'(`PWM_RST_PRESCALE))
  ) u_prescale (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .wr_en      (wr_prescale),
    .wr_data    (reg_wr.data),
    .load       (load_event),
    .pre_val    (),
    .active_val (act_prescale)
  );

  shadow_reg #(
    .T       (word_t),
    .RST_VAL (word_t'(`PWM_RST_PERIOD))
  ) u_period (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .wr_en      (wr_period),
    .wr_data    (reg_wr.data),
    .load       (load_event),
    .pre_val    (),
    .active_val (act_period)
  );

  shadow_reg #(
    .T       (chan_en_t),
    .RST_VAL ('0)
  ) u_enable (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .wr_en      (wr_enable),
    .wr_data    (chan_en_t'(reg_wr.data)),
    .load       (load_event),
    .pre_val    (pre_enable),
    .active_val (act_enable)
  );

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_update <= 1'b0;
    end
    else if (reg_wr.valid && (reg_wr.addr == reg_addr_t'(`PWM_ADDR_SYNC_UPDATE)))
    begin
      sync_update <= reg_wr.data[0];
    end
  end

  // unmasked channels follow software writes at once
  assign vis_enable = (act_enable & SHADOW_MASK) | (pre_enable & ~SHADOW_MASK);

  assign global_cfg = '{prescale: act_prescale, period: act_period, enable: vis_enable};

endmodule

// ==== hw/wb_reg_port.sv ====
/* wishbone classic slave, one ack per request, no wait states and no error response
   the master must drop stb in the cycle after ack */
`timescale 1ns/1ns

module wb_reg_port (
  input  logic                  pclk,
  input  logic                  rst_n,
  input  pwm_reg_pkg::wb_req_t  wb_req,
  output logic                  wb_ack,
  output pwm_reg_pkg::word_t    wb_dat_r,
  output pwm_reg_pkg::reg_addr_t rd_addr,
  input  pwm_reg_pkg::word_t    rd_data,
  output pwm_reg_pkg::reg_wr_t  reg_wr
);

  import pwm_reg_pkg::*;

  logic      req;
  logic      accept;
  logic      wr_valid;
  reg_addr_t wr_addr;
  word_t     wr_data;

  assign req    = wb_req.cyc && wb_req.stb;
  // a request is taken only while ack is low
  assign accept = req && !wb_ack;

  // read mux decodes straight from the bus address
  assign rd_addr = wb_req.adr;

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack   <= 1'b0;
      wr_valid <= 1'b0;
      wb_dat_r <= '0;
    end
    else
    begin
      wb_ack   <= accept;
      wr_valid <= accept && wb_req.we;
      if (accept && !wb_req.we)
      begin
        wb_dat_r <= rd_data;
      end
    end
  end

  // write payload, valid alongside ack
  always_ff @(posedge pclk)
  begin
    if (accept)
    begin
      wr_addr <= wb_req.adr;
      wr_data <= wb_req.dat;
    end
  end

  assign reg_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

// ==== hw/shadow_reg.sv ====
/* pre-shadow and active register pair for any packed payload
   a write and a load in the same cycle load the old pre-shadow value */
`timescale 1ns/1ns

module shadow_reg #(
  parameter type T       = logic [7:0],
  parameter T    RST_VAL = '0
) (
  input  logic pclk,
  input  logic rst_n,
  input  logic wr_en,
  input  T     wr_data,
  input  logic load,
  output T     pre_val,
  output T     active_val
);

  // software copy
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pre_val <= RST_VAL;
    end
    else if (wr_en)
    begin
      pre_val <= wr_data;
    end
  end

  // copy in force, taken over on a load event
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_val <= RST_VAL;
    end
    else if (load)
    begin
      active_val <= pre_val;
    end
  end

endmodule

// ==== hw/pwm_reg_pkg.sv ====
/* shared types of the PWM register block
   widths follow the defines in pwm_reg_defs.svh */
`include "pwm_reg_defs.svh"

package pwm_reg_pkg;

  typedef logic [`PWM_DW-1:0]       word_t;
  typedef logic [`PWM_AW-1:0]       reg_addr_t;
  typedef logic [`PWM_CHANNELS-1:0] chan_en_t;

  // compare values of one channel
  typedef struct packed {
    word_t rise;
    word_t fall;
  } edge_pair_t;

  // index k holds channel k
  typedef edge_pair_t [`PWM_CHANNELS-1:0] edge_cfg_t;

  // settings shared by all channels
  typedef struct packed {
    word_t    prescale;
    word_t    period;
    chan_en_t enable;
  } global_cfg_t;

  // wishbone classic request from the master
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    word_t     dat;
  } wb_req_t;

  // one-cycle write strobe into the register banks
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    word_t     data;
  } reg_wr_t;

endpackage

// ==== include/pwm_reg_defs.svh ====
/* register map constants for the 8-channel PWM register block
   edge registers of channel k sit at EDGE_BASE + 2k (rise) and EDGE_BASE + 2k + 1 (fall) */
`ifndef PWM_REG_DEFS_SVH
`define PWM_REG_DEFS_SVH

`define PWM_DW       8
`define PWM_CHANNELS 8
`define PWM_AW       6

// bit set: enable and edges of that channel come from the active copy
`define PWM_SHADOW_MASK 8'h0F

// register addresses
`define PWM_ADDR_PRESCALE    0
`define PWM_ADDR_PERIOD      1
`define PWM_ADDR_ENABLE      2
`define PWM_ADDR_EDGE_BASE   4
`define PWM_ADDR_SYNC_UPDATE 57

// reset values
`define PWM_RST_PRESCALE 8
`define PWM_RST_PERIOD   8

`endif
